/* all.f */
common/rv_pkg.sv
fetch/rv_fetch.sv
fetch/rv_decode.sv
execute/rv_regfile.sv
execute/rv_execute.sv
design/rv_lsu.sv
design/rv_core_top.sv
tb/core_properties.sv
tb/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the core testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f all.f -o core_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "no result line in the log"
	exit 1
fi
exit 0

/* tb/core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam logic [31:0] RES_BASE = 32'h0000_0400;   // one result word per test
	localparam logic [31:0] BAD_ADDR = 32'h0000_1100;   // store behind a taken transfer
	localparam logic [31:0] END_ADDR = 32'h0000_1200;   // final marker store
	localparam int HALT_CYCLES = 6;

	logic clk;
	logic rst_n;
	logic halt;
	rv_pkg::word_t in_data;
	rv_pkg::word_t data_in;
	rv_pkg::word_t in_addr;
	rv_pkg::word_t address;
	rv_pkg::word_t data_out;
	logic [3:0] be;
	logic read_e;
	logic write_e;

	logic [31:0] rom [1024];   // instruction memory
	logic [31:0] ram [4096];   // 16 KiB data memory
	logic [31:0] exp_val [256];
	string names [256];
	int pc_w;                  // next rom word to fill
	int n_res;
	int seen;
	int res_idx;
	int seed = 32'h22b3_63fc;
	bit built;

	rv_core_top i_dut (
		.clk(clk), .rst_n(rst_n), .halt(halt), .in_data(in_data), .data_in(data_in),
		.in_addr(in_addr), .address(address), .data_out(data_out), .be(be),
		.read_e(read_e), .write_e(write_e)
	);

	bind rv_core_top core_properties i_props (
		.clk(clk), .rst_n(rst_n), .halt(halt), .in_addr(in_addr), .address(address),
		.data_out(data_out), .be(be), .read_e(read_e), .write_e(write_e),
		.rs2_data(rs2_data), .funct3(dec.funct3)
	);

	assign in_data = rom[in_addr[11:2]];                  // combinational rom
	assign data_in = read_e ? ram[address[13:2]] : '0;   // read data only while read_e

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;   // 40 ns period
	end

	////////////////////////////////////////////////////////////
	// instruction encoders for the rv32i formats
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm[11:0], rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_u(logic [31:0] v, logic [4:0] rd, logic [6:0] op);
		return {v[31:12], rd, op};   // upper 20 bits only
	endfunction

	function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// ram preset that differs per word
	function automatic logic [31:0] fill_word(logic [31:0] idx);
		return (idx * 32'h9E37_79B1) ^ 32'h5A3C_E1F0;
	endfunction

	function automatic logic branch_rule(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic emit(input logic [31:0] w);
		rom[pc_w] = w;
		pc_w++;
	endtask

	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		emit(enc_u(v + 32'h800, rd, rv_pkg::op_lui));   // round for sign of addi
		emit(enc_i(v, rd, 3'd0, rd, rv_pkg::op_imm));
	endtask

	task automatic store_result(input logic [4:0] rs, input string nm, input logic [31:0] v);
		emit(enc_s(RES_BASE + 32'(4 * n_res), rs, 5'd0, 3'd2));
		exp_val[n_res] = v;
		names[n_res] = nm;
		n_res++;
	endtask

	task automatic emit_bad_marker();
		emit(enc_s(32'h100, 5'd0, 5'd4, 3'd2));   // sw x0, 0x100(x4)
	endtask

	////////////////////////////////////////////////////////////
	// test program
	////////////////////////////////////////////////////////////

	task automatic build_program();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		logic [31:0] w;
		logic [31:0] p;
		logic [2:0] br_fns [6];
		int n_fall;
		br_fns = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		n_fall = 0;
		store_result(5'd2, "reset sp", rv_pkg::RESET_SP);   // first instruction
		emit(enc_u(32'h1000, 5'd4, rv_pkg::op_lui));        // x4 = store area
		emit(enc_u(32'h2000, 5'd5, rv_pkg::op_lui));        // x5 = load area
		a = $random(seed);
		b = $random(seed);
		load_const(5'd7, a);
		load_const(5'd8, b);
		store_result(5'd7, "li a", a);
		emit(enc_r(7'h00, 5'd8, 5'd7, 3'd0, 5'd9));
		store_result(5'd9, "add", a + b);
		emit(enc_r(7'h20, 5'd8, 5'd7, 3'd0, 5'd9));
		store_result(5'd9, "sub", a - b);
		emit(enc_r(7'h00, 5'd8, 5'd7, 3'd4, 5'd9));
		store_result(5'd9, "xor", a ^ b);
		emit(enc_r(7'h00, 5'd8, 5'd7, 3'd6, 5'd9));
		store_result(5'd9, "or", a | b);
		emit(enc_r(7'h00, 5'd8, 5'd7, 3'd7, 5'd9));
		store_result(5'd9, "and", a & b);
		emit(enc_r(7'h00, 5'd8, 5'd7, 3'd1, 5'd9));
		store_result(5'd9, "sll", a << b[4:0]);
		emit(enc_r(7'h00, 5'd8, 5'd7, 3'd5, 5'd9));
		store_result(5'd9, "srl", a >> b[4:0]);
		emit(enc_r(7'h20, 5'd8, 5'd7, 3'd5, 5'd9));
		store_result(5'd9, "sra", 32'($signed(a) >>> b[4:0]));
		emit(enc_r(7'h00, 5'd8, 5'd7, 3'd2, 5'd9));
		store_result(5'd9, "slt", {31'd0, $signed(a) < $signed(b)});
		emit(enc_r(7'h00, 5'd8, 5'd7, 3'd3, 5'd9));
		store_result(5'd9, "sltu", {31'd0, a < b});
		r = $random(seed);
		emit(enc_i(r, 5'd7, 3'd0, 5'd9, rv_pkg::op_imm));
		store_result(5'd9, "addi", a + {{20{r[11]}}, r[11:0]});
		r = $random(seed);
		emit(enc_u(r, 5'd9, rv_pkg::op_lui));
		store_result(5'd9, "lui", {r[31:12], 12'd0});
		p = 32'(pc_w * 4);   // pc of the auipc
		emit(enc_u(r, 5'd9, rv_pkg::op_auipc));
		store_result(5'd9, "auipc", p + {r[31:12], 12'd0});
		// sub-word stores at every legal offset
		for (int off = 0; off < 4; off++)
			emit(enc_s(32'(off), 5'd7, 5'd4, 3'd0));
		emit(enc_s(32'd0, 5'd8, 5'd4, 3'd1));
		emit(enc_s(32'd2, 5'd8, 5'd4, 3'd1));
		// loads from preset words
		for (int off = 0; off < 4; off++)
		begin
			w = fill_word(32'h800 + 32'(off));
			emit(enc_i(32'(4 * off + off), 5'd5, 3'd0, 5'd6, rv_pkg::op_load));
			store_result(5'd6, "lb", {{24{w[8*off+7]}}, w[8*off +: 8]});
			emit(enc_i(32'(4 * off + off), 5'd5, 3'd4, 5'd6, rv_pkg::op_load));
			store_result(5'd6, "lbu", {24'd0, w[8*off +: 8]});
		end
		for (int off = 0; off < 4; off += 2)
		begin
			w = fill_word(32'h804 + 32'(off));
			emit(enc_i(32'(16 + 4 * off + off), 5'd5, 3'd1, 5'd6, rv_pkg::op_load));
			store_result(5'd6, "lh", {{16{w[8*off+15]}}, w[8*off +: 16]});
			emit(enc_i(32'(16 + 4 * off + off), 5'd5, 3'd5, 5'd6, rv_pkg::op_load));
			store_result(5'd6, "lhu", {16'd0, w[8*off +: 16]});
		end
		emit(enc_i(32'd32, 5'd5, 3'd2, 5'd6, rv_pkg::op_load));
		store_result(5'd6, "lw", fill_word(32'h808));
		// all six branches with both operand orders and equal operands
		for (int k = 0; k < 6; k++)
		begin
			for (int q = 0; q < 3; q++)
			begin
				emit(enc_b(32'd8, (q == 0) ? 5'd8 : 5'd7, (q == 1) ? 5'd8 : 5'd7, br_fns[k]));
				if (branch_rule(br_fns[k], (q == 1) ? b : a, (q == 0) ? b : a))
					emit_bad_marker();   // must be squashed
				else
				begin
					emit(enc_i(32'd1, 5'd10, 3'd0, 5'd10, rv_pkg::op_imm));
					n_fall++;
				end
			end
		end
		store_result(5'd10, "branch fallthrough count", 32'(n_fall));
		p = 32'(pc_w * 4);
		emit(enc_j(32'd8, 5'd11));
		emit_bad_marker();
		store_result(5'd11, "jal link", p + 32'd4);
		p = 32'(pc_w * 4);
		emit(enc_u(32'd0, 5'd12, rv_pkg::op_auipc));               // x12 = own pc
		emit(enc_i(32'd16, 5'd12, 3'd0, 5'd13, rv_pkg::op_jalr));   // to p + 16
		emit_bad_marker();
		emit_bad_marker();
		store_result(5'd13, "jalr link", p + 32'd8);
		emit(enc_s(32'h200, 5'd0, 5'd4, 3'd2));   // final marker
		emit(enc_j(32'd0, 5'd0));                 // park
	endtask

	////////////////////////////////////////////////////////////
	// memory write and result checks
	////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		if (rst_n && write_e)
		begin
			for (int l = 0; l < 4; l++)
				if (be[l])
					ram[address[13:2]][8*l +: 8] <= data_out[8*l +: 8];
			if (address == BAD_ADDR)
			begin
				$display("store behind a taken branch or jump was executed at %h", address);
				$display("RESULT: FAIL");
				$fatal(1);
			end
			else if (address == END_ADDR)
			begin
				if (seen == n_res)
				begin
					$display("RESULT: PASS");
					$finish;
				end
				else
				begin
					$display("only %0d of %0d result stores were seen", seen, n_res);
					$display("RESULT: FAIL");
					$fatal(1);
				end
			end
			else if (address >= RES_BASE && address < RES_BASE + 32'(4 * n_res))
			begin
				res_idx = int'((address - RES_BASE) >> 2);
				assert (data_out == exp_val[res_idx])
				else
				begin
					$display("Fail %s expected %h actual %h", names[res_idx],
						exp_val[res_idx], data_out);
					$display("RESULT: FAIL");
					$fatal(1);
				end
				seen++;
			end
		end
	end

	initial
	begin
		rst_n = 1'b0;
		halt = 1'b0;
		pc_w = 0;
		n_res = 0;
		seen = 0;
		for (int i = 0; i < 1024; i++)
			rom[i] = 32'd0;
		for (int i = 0; i < 4096; i++)
			ram[i] = fill_word(32'(i));
		build_program();
		built = 1'b1;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		repeat (40) @(negedge clk);   // halt in mid program
		halt = 1'b1;
		repeat (HALT_CYCLES) @(negedge clk);
		halt = 1'b0;
	end

	// three cycles per instruction covers every bubble
	initial
	begin
		wait (built);
		repeat (pc_w * 3 + HALT_CYCLES + 10) @(posedge clk);
		$display("timeout: the program never reached its final marker store");
		$display("RESULT: FAIL");
		$fatal(1);
	end

endmodule

`default_nettype wire

/* tb/core_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module core_properties (
	input logic          clk,
	input logic          rst_n,
	input logic          halt,
	input rv_pkg::word_t in_addr,
	input rv_pkg::word_t address,
	input rv_pkg::word_t data_out,
	input logic [3:0]    be,
	input logic          read_e,
	input logic          write_e,
	input rv_pkg::word_t rs2_data,   // store source register
	input logic [2:0]    funct3
);

	// lanes a store of this size and offset may touch
	function automatic logic [3:0] lane_mask(logic [2:0] f3, logic [1:0] off);
		case (f3[1:0])
			2'd0: return 4'b0001 << off;
			2'd1: return off[1] ? 4'b1100 : 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic logic lanes_hold(logic [2:0] f3, logic [1:0] off, logic [31:0] d,
		logic [31:0] r);
		case (f3[1:0])
			2'd0: return d[8*off +: 8] == r[7:0];
			2'd1: return off[1] ? d[31:16] == r[15:0] : d[15:0] == r[15:0];
			default: return d == r;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// reset and halt
	////////////////////////////////////////////////////////////

	a_reset_quiet: assert property (@(posedge clk)
		!rst_n && $past(!rst_n) |-> !read_e && !write_e)
		else $error("memory strobe during reset");

	a_reset_pc: assert property (@(posedge clk)
		$rose(rst_n) |-> in_addr == rv_pkg::RESET_PC)
		else $error("fetch address after reset is not the reset pc");

	a_halt_quiet: assert property (@(posedge clk)
		rst_n && halt |-> !read_e && !write_e)
		else $error("memory strobe while halted");

	a_halt_hold: assert property (@(posedge clk)
		rst_n && $past(rst_n) && $past(halt) |-> $stable(in_addr))
		else $error("fetch address moved while halted");

	////////////////////////////////////////////////////////////
	// store port
	////////////////////////////////////////////////////////////

	a_be_rule: assert property (@(posedge clk)
		rst_n && write_e |-> be == lane_mask(funct3, address[1:0]))
		else $error("byte enables do not match size and offset");

	a_lanes: assert property (@(posedge clk)
		rst_n && write_e |-> lanes_hold(funct3, address[1:0], data_out, rs2_data))
		else $error("store data not in its lanes");

endmodule

`default_nettype wire

/* design/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          halt,
	input  rv_pkg::word_t in_data,     // instruction word for in_addr
	input  rv_pkg::word_t data_in,     // read data for address
	output rv_pkg::word_t in_addr,
	output rv_pkg::word_t address,
	output rv_pkg::word_t data_out,
	output logic [3:0]    be,
	output logic          read_e,
	output logic          write_e
);

	rv_pkg::word_t     instr;
	rv_pkg::word_t     instr_pc;
	logic              flush;
	logic              redirect;
	rv_pkg::word_t     target;
	rv_pkg::decoded_t  dec;
	rv_pkg::word_t     rs1_data;
	rv_pkg::word_t     rs2_data;
	logic              wr_en;
	rv_pkg::reg_addr_t wr_rd;
	rv_pkg::word_t     wr_data;
	rv_pkg::word_t     load_data;
	rv_pkg::mem_req_t  req;

	////////////////////////////////////////////////////////////
	// input side, fetch and decode
	////////////////////////////////////////////////////////////

	rv_fetch i_fetch (
		.clk      (clk),
		.rst_n    (rst_n),
		.halt     (halt),
		.in_data  (in_data),
		.redirect (redirect),
		.target   (target),
		.in_addr  (in_addr),
		.instr    (instr),
		.instr_pc (instr_pc),
		.flush    (flush)
	);

	rv_decode i_decode (
		.instr    (instr),
		.instr_pc (instr_pc),
		.flush    (flush),
		.dec      (dec)
	);

	////////////////////////////////////////////////////////////
	// processing, registers and execute
	////////////////////////////////////////////////////////////

	rv_regfile i_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.halt     (halt),
		.rs1      (dec.rs1),
		.rs2      (dec.rs2),
		.rd       (wr_rd),
		.wr_en    (wr_en),
		.wr_data  (wr_data),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	rv_execute i_execute (
		.dec       (dec),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.load_data (load_data),
		.redirect  (redirect),
		.target    (target),
		.wr_en     (wr_en),
		.rd        (wr_rd),
		.wr_data   (wr_data)
	);

	////////////////////////////////////////////////////////////
	// output side, data memory port
	////////////////////////////////////////////////////////////

	rv_lsu i_lsu (
		.dec       (dec),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data),
		.data_in   (data_in),
		.req       (req),
		.load_data (load_data)
	);

	assign address  = req.address;
	assign data_out = req.wdata;
	assign be       = req.be;
	assign read_e   = req.read & ~halt;    // no access while halted
	assign write_e  = req.write & ~halt;

endmodule

`default_nettype wire

/* design/rv_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_lsu (
	input  rv_pkg::decoded_t dec,
	input  rv_pkg::word_t    rs1_data,
	input  rv_pkg::word_t    rs2_data,
	input  rv_pkg::word_t    data_in,     // combinational read data
	output rv_pkg::mem_req_t req,
	output rv_pkg::word_t    load_data
);

	rv_pkg::word_t     addr;
	rv_pkg::mem_size_e size;
	logic [7:0]        ld_byte;
	logic [15:0]       ld_half;

	assign addr = rs1_data + dec.imm;
	assign size = rv_pkg::mem_size_e'(dec.funct3);

	////////////////////////////////////////////////////////////
	// byte enables and store lanes
	////////////////////////////////////////////////////////////

	always_comb
	begin
		req.address = addr;
		req.read    = dec.opcode == rv_pkg::op_load;
		req.write   = dec.opcode == rv_pkg::op_store;
		case (size)
			rv_pkg::mem_byte,
			rv_pkg::mem_byte_u:
			begin
				req.be    = 4'b0001 << addr[1:0];                         // one lane
				req.wdata = {24'b0, rs2_data[7:0]} << {addr[1:0], 3'b000};   // other lanes zero
			end
			rv_pkg::mem_half,
			rv_pkg::mem_half_u:
			begin
				req.be    = addr[1] ? 4'b1100 : 4'b0011;   // upper or lower half
				req.wdata = addr[1] ? {rs2_data[15:0], 16'b0} : {16'b0, rs2_data[15:0]};
			end
			default:
			begin
				req.be    = 4'b1111;   // word
				req.wdata = rs2_data;
			end
		endcase
	end

	// load lane pick and extension
	assign ld_byte = data_in[{addr[1:0], 3'b000} +: 8];
	assign ld_half = addr[1] ? data_in[31:16] : data_in[15:0];

	always_comb
	begin
		case (size)
			rv_pkg::mem_byte:   load_data = {{24{ld_byte[7]}}, ld_byte};
			rv_pkg::mem_byte_u: load_data = {24'b0, ld_byte};
			rv_pkg::mem_half:   load_data = {{16{ld_half[15]}}, ld_half};
			rv_pkg::mem_half_u: load_data = {16'b0, ld_half};
			default:            load_data = data_in;   // lw
		endcase
	end

endmodule

`default_nettype wire

/* execute/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	input  rv_pkg::decoded_t  dec,
	input  rv_pkg::word_t     rs1_data,
	input  rv_pkg::word_t     rs2_data,
	input  rv_pkg::word_t     load_data,   // extended by the lsu
	output logic              redirect,
	output rv_pkg::word_t     target,
	output logic              wr_en,
	output rv_pkg::reg_addr_t rd,
	output rv_pkg::word_t     wr_data
);

	rv_pkg::word_t op_b;      // rs2 or immediate
	rv_pkg::word_t alu_res;
	rv_pkg::word_t jump_sum;
	logic          taken;

	assign op_b = (dec.opcode == rv_pkg::op_imm) ? dec.imm : rs2_data;

	////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (rv_pkg::alu_fn_e'(dec.funct3))
			rv_pkg::alu_add:
				alu_res = (dec.opcode == rv_pkg::op_reg && dec.alt) ? rs1_data - op_b
					: rs1_data + op_b;   // addi never subtracts
			rv_pkg::alu_sll:  alu_res = rs1_data << op_b[4:0];
			rv_pkg::alu_slt:  alu_res = rv_pkg::word_t'($signed(rs1_data) < $signed(op_b));
			rv_pkg::alu_sltu: alu_res = rv_pkg::word_t'(rs1_data < op_b);
			rv_pkg::alu_xor:  alu_res = rs1_data ^ op_b;
			rv_pkg::alu_srl:
				alu_res = dec.alt ? rv_pkg::word_t'($signed(rs1_data) >>> op_b[4:0])
					: rs1_data >> op_b[4:0];   // sra vs srl
			rv_pkg::alu_or:   alu_res = rs1_data | op_b;
			default:          alu_res = rs1_data & op_b;
		endcase
	end

	// branch compare, always on rs2
	always_comb
	begin
		case (rv_pkg::branch_fn_e'(dec.funct3))
			rv_pkg::br_beq:  taken = rs1_data == rs2_data;
			rv_pkg::br_bne:  taken = rs1_data != rs2_data;
			rv_pkg::br_blt:  taken = $signed(rs1_data) < $signed(rs2_data);
			rv_pkg::br_bge:  taken = $signed(rs1_data) >= $signed(rs2_data);
			rv_pkg::br_bltu: taken = rs1_data < rs2_data;
			rv_pkg::br_bgeu: taken = rs1_data >= rs2_data;
			default:         taken = 1'b0;   // reserved funct3
		endcase
	end

	////////////////////////////////////////////////////////////
	// control transfer
	////////////////////////////////////////////////////////////

	assign jump_sum = ((dec.opcode == rv_pkg::op_jalr) ? rs1_data : dec.pc) + dec.imm;
	assign target   = {jump_sum[31:1], jump_sum[0] & (dec.opcode != rv_pkg::op_jalr)};
	assign redirect = (dec.opcode == rv_pkg::op_jal) || (dec.opcode == rv_pkg::op_jalr)
		|| (dec.opcode == rv_pkg::op_branch && taken);

	// write-back select
	always_comb
	begin
		wr_en = 1'b1;
		case (dec.opcode)
			rv_pkg::op_lui:   wr_data = dec.imm;
			rv_pkg::op_auipc: wr_data = dec.pc + dec.imm;
			rv_pkg::op_jal,
			rv_pkg::op_jalr:  wr_data = dec.pc + rv_pkg::INSTR_BYTES;   // link
			rv_pkg::op_load:  wr_data = load_data;
			rv_pkg::op_imm,
			rv_pkg::op_reg:   wr_data = alu_res;
			default:
			begin
				wr_en   = 1'b0;        // branch, store, bubble
				wr_data = alu_res;
			end
		endcase
	end

	assign rd = dec.rd;

endmodule

`default_nettype wire

/* execute/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              halt,
	input  rv_pkg::reg_addr_t rs1,
	input  rv_pkg::reg_addr_t rs2,
	input  rv_pkg::reg_addr_t rd,
	input  logic              wr_en,
	input  rv_pkg::word_t     wr_data,
	output rv_pkg::word_t     rs1_data,   // async read
	output rv_pkg::word_t     rs2_data
);

	rv_pkg::word_t regs [rv_pkg::REG_COUNT];

	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < rv_pkg::REG_COUNT; i++)
			begin
				regs[i] <= (i == rv_pkg::SP_INDEX) ? rv_pkg::RESET_SP : '0;   // sp preset
			end
		end
		else if (wr_en && !halt && rd != '0)   // x0 stays zero
		begin
			regs[rd] <= wr_data;
		end
	end

endmodule

`default_nettype wire

/* fetch/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
	input  logic             [31:0] instr,
	input  rv_pkg::word_t    instr_pc,
	input  logic             flush,
	output rv_pkg::decoded_t dec
);

	rv_pkg::opcode_e op;      // class before squash
	rv_pkg::word_t   imm;

	// opcode classification
	always_comb
	begin
		case (instr[6:0])
			rv_pkg::op_lui:    op = rv_pkg::op_lui;
			rv_pkg::op_auipc:  op = rv_pkg::op_auipc;
			rv_pkg::op_jal:    op = rv_pkg::op_jal;
			rv_pkg::op_jalr:   op = rv_pkg::op_jalr;
			rv_pkg::op_branch: op = rv_pkg::op_branch;
			rv_pkg::op_load:   op = rv_pkg::op_load;
			rv_pkg::op_store:  op = rv_pkg::op_store;
			rv_pkg::op_imm:    op = rv_pkg::op_imm;
			rv_pkg::op_reg:    op = rv_pkg::op_reg;
			default:           op = rv_pkg::op_none;   // unknown acts as nop
		endcase
	end

	////////////////////////////////////////////////////////////
	// immediate per format
	////////////////////////////////////////////////////////////

	always_comb
	begin
		case (op)
			rv_pkg::op_store:   // s-type
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			rv_pkg::op_branch:  // b-type, bit 0 zero
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			rv_pkg::op_lui,
			rv_pkg::op_auipc:   // u-type
				imm = {instr[31:12], 12'b0};
			rv_pkg::op_jal:     // j-type
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default:            // i-type, also jalr and loads
				imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	always_comb
	begin
		dec.opcode = flush ? rv_pkg::op_none : op;   // bubble kills the slot
		dec.rd     = instr[11:7];
		dec.rs1    = instr[19:15];
		dec.rs2    = instr[24:20];
		dec.funct3 = instr[14:12];
		dec.alt    = instr[30];     // sub and sra select
		dec.imm    = imm;
		dec.pc     = instr_pc;
	end

endmodule

`default_nettype wire

/* fetch/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_fetch (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          halt,
	input  rv_pkg::word_t in_data,    // rom output for in_addr
	input  logic          redirect,   // taken branch or jump
	input  rv_pkg::word_t target,
	output rv_pkg::word_t in_addr,
	output rv_pkg::word_t instr,      // instruction register
	output rv_pkg::word_t instr_pc,
	output logic          flush       // instr is a bubble
);

	rv_pkg::word_t pc;        // fetch address
	rv_pkg::word_t pc_next;

	assign pc_next = redirect ? target : pc + rv_pkg::INSTR_BYTES;
	assign in_addr = pc;

	////////////////////////////////////////////////////////////
	// pc and flush flag
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pc    <= rv_pkg::RESET_PC;
			flush <= 1'b1;               // first word after reset is junk
		end
		else if (!halt)
		begin
			pc    <= pc_next;
			flush <= redirect;           // squash the word behind a jump
		end
	end

	// instruction register, masked by flush until valid
	always_ff @(posedge clk)
	begin
		if (!halt)
		begin
			instr    <= in_data;
			instr_pc <= pc;              // pc of the word just latched
		end
	end

endmodule

`default_nettype wire

/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	localparam int unsigned XLEN = 32;        // data and address width
	localparam int unsigned REG_COUNT = 32;   // architectural registers
	localparam int unsigned REG_ADDR_W = 5;   // register index width
	localparam int unsigned SP_INDEX = 2;     // x2 is the stack pointer

	typedef logic [XLEN-1:0] word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	localparam word_t RESET_SP = 32'd8192;    // sp after reset
	localparam word_t INSTR_BYTES = 32'd4;    // pc step
	localparam word_t RESET_PC = 32'd0;       // first fetch address

	////////////////////////////////////////////////////////////
	// encodings, opcode field and funct3
	////////////////////////////////////////////////////////////

	typedef enum logic [6:0] {
		op_none   = 7'b0000000,   // squashed or unknown
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add  = 3'b000,   // sub when alt on reg ops
		alu_sll  = 3'b001,
		alu_slt  = 3'b010,
		alu_sltu = 3'b011,
		alu_xor  = 3'b100,
		alu_srl  = 3'b101,   // sra when alt
		alu_or   = 3'b110,
		alu_and  = 3'b111
	} alu_fn_e;

	typedef enum logic [2:0] {
		br_beq  = 3'b000,
		br_bne  = 3'b001,
		br_blt  = 3'b100,
		br_bge  = 3'b101,
		br_bltu = 3'b110,
		br_bgeu = 3'b111
	} branch_fn_e;

	typedef enum logic [2:0] {
		mem_byte   = 3'b000,
		mem_half   = 3'b001,
		mem_word   = 3'b010,
		mem_byte_u = 3'b100,
		mem_half_u = 3'b101
	} mem_size_e;

	typedef struct packed {
		opcode_e   opcode;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		logic [2:0] funct3;
		logic       alt;      // funct7 bit 5
		word_t      imm;      // sign extended
		word_t      pc;       // address of this instruction
	} decoded_t;

	typedef struct packed {
		word_t      address;
		word_t      wdata;
		logic [3:0] be;
		logic       read;
		logic       write;
	} mem_req_t;

endpackage

`default_nettype wire
